/* core_pkg.sv */
`default_nettype none

package core_pkg;

	// ************************************************
	// widths and reset constants
	// ************************************************
	localparam int xlen = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
	// stack pointer preset
	localparam logic [xlen-1:0] sp_reset = 32'd1000;
	// addi x0, x0, 0
	localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;

	// ************************************************
	// opcodes and control encodings
	// ************************************************
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_op_imm = 7'b0010011,
		op_op     = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_copy_b
	} alu_op_e;

	typedef enum logic [3:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_bltu,
		br_bgeu,
		br_jal,
		br_jalr
	} br_kind_e;

	// data port command, none must stay zero
	typedef enum logic [1:0] {
		mem_none  = 2'd0,
		mem_load  = 2'd1,
		mem_store = 2'd2
	} mem_cmd_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel_e;

	// ************************************************
	// pipeline registers
	// ************************************************
	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] inst;
	} if_id_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] pc;
		alu_op_e         alu_op;
		logic [xlen-1:0] op1;
		logic [xlen-1:0] op2;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
		br_kind_e        br_kind;
		mem_cmd_e        mem_cmd;
		logic [4:0]      rd;
		logic            rf_wen;
		wb_sel_e         wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic            valid;
		logic [xlen-1:0] alu_out;
		logic [xlen-1:0] pc4;
		logic [xlen-1:0] rs2_data;
		mem_cmd_e        mem_cmd;
		logic [4:0]      rd;
		logic            rf_wen;
		wb_sel_e         wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic            valid;
		logic [4:0]      rd;
		logic            rf_wen;
		logic [xlen-1:0] wb_data;
	} mem_wb_t;

	typedef struct packed {
		logic            taken;
		logic [xlen-1:0] target;
	} redirect_t;

endpackage

`default_nettype wire

/* register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module register_file (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire core_pkg::mem_wb_t    mem_wb,
	input  wire logic [4:0]           rs1_addr,
	input  wire logic [4:0]           rs2_addr,
	output logic [core_pkg::xlen-1:0] rs1_data,
	output logic [core_pkg::xlen-1:0] rs2_data,
	output logic                      retire_valid,
	output logic [4:0]                retire_rd,
	output logic [core_pkg::xlen-1:0] retire_data
);

	// x0 has no storage
	logic [core_pkg::xlen-1:0] regs [1:31];
	logic                      wr_en;

	assign wr_en = mem_wb.valid && mem_wb.rf_wen && (mem_wb.rd != 5'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= (i == 2) ? core_pkg::sp_reset : '0;
			end
		end else if (wr_en) begin
			regs[mem_wb.rd] <= mem_wb.wb_data;
		end
	end

	// reads see the write of the same cycle
	assign rs1_data = (rs1_addr == 5'd0) ? '0
		: (wr_en && mem_wb.rd == rs1_addr) ? mem_wb.wb_data : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0
		: (wr_en && mem_wb.rd == rs2_addr) ? mem_wb.wb_data : regs[rs2_addr];

	assign retire_valid = wr_en;
	assign retire_rd    = mem_wb.rd;
	assign retire_data  = mem_wb.wb_data;

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      stall,
	input  wire core_pkg::redirect_t       redirect,
	output logic [core_pkg::xlen-1:0]      i_addr,
	input  wire logic [core_pkg::xlen-1:0] inst,
	output core_pkg::if_id_t               if_id
);

	logic [core_pkg::xlen-1:0] pc;

	assign i_addr = pc;

	// redirect has priority over the decode stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= core_pkg::reset_pc;
		end else if (redirect.taken) begin
			pc <= redirect.target;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	// fetch/decode register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= '{valid: 1'b0, pc: core_pkg::reset_pc, inst: core_pkg::nop_inst};
		end else if (redirect.taken) begin
			// wrong-path slot becomes a bubble
			if_id.valid <= 1'b0;
			if_id.inst  <= core_pkg::nop_inst;
		end else if (!stall) begin
			if_id.valid <= 1'b1;
			if_id.pc    <= pc;
			if_id.inst  <= inst;
		end
	end

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire core_pkg::if_id_t          if_id,
	input  wire core_pkg::ex_mem_t         ex_hazard,
	input  wire core_pkg::mem_wb_t         wb_hazard,
	input  wire core_pkg::redirect_t       redirect,
	output logic [4:0]                     rs1_addr,
	output logic [4:0]                     rs2_addr,
	input  wire logic [core_pkg::xlen-1:0] rs1_data,
	input  wire logic [core_pkg::xlen-1:0] rs2_data,
	output logic                           stall,
	output core_pkg::id_ex_t               id_ex
);

	core_pkg::opcode_e         opcode;
	logic [2:0]                funct3;
	logic [4:0]                rd;
	logic [core_pkg::xlen-1:0] imm_i;
	logic [core_pkg::xlen-1:0] imm_s;
	logic [core_pkg::xlen-1:0] imm_b;
	logic [core_pkg::xlen-1:0] imm_u;
	logic [core_pkg::xlen-1:0] imm_j;
	logic                      uses_rs1;
	logic                      uses_rs2;
	logic                      hz_ex;
	logic                      hz_mem;
	core_pkg::id_ex_t          dec;

	function automatic core_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: alu_of = alt ? core_pkg::alu_sub : core_pkg::alu_add;
			3'b001: alu_of = core_pkg::alu_sll;
			3'b010: alu_of = core_pkg::alu_slt;
			3'b011: alu_of = core_pkg::alu_sltu;
			3'b100: alu_of = core_pkg::alu_xor;
			3'b101: alu_of = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			3'b110: alu_of = core_pkg::alu_or;
			default: alu_of = core_pkg::alu_and;
		endcase
	endfunction

	assign opcode   = core_pkg::opcode_e'(if_id.inst[6:0]);
	assign funct3   = if_id.inst[14:12];
	assign rd       = if_id.inst[11:7];
	assign rs1_addr = if_id.inst[19:15];
	assign rs2_addr = if_id.inst[24:20];

	// ************************************************
	// immediates
	// ************************************************
	assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
	assign imm_s = {{20{if_id.inst[31]}}, if_id.inst[31:25], if_id.inst[11:7]};
	assign imm_b = {{19{if_id.inst[31]}}, if_id.inst[31], if_id.inst[7],
		if_id.inst[30:25], if_id.inst[11:8], 1'b0};
	assign imm_u = {if_id.inst[31:12], 12'b0};
	assign imm_j = {{11{if_id.inst[31]}}, if_id.inst[31], if_id.inst[19:12],
		if_id.inst[20], if_id.inst[30:21], 1'b0};

	// ************************************************
	// interlock against producers in execute and memory
	// ************************************************
	assign uses_rs1 = opcode inside {core_pkg::op_jalr, core_pkg::op_branch, core_pkg::op_load,
		core_pkg::op_store, core_pkg::op_op_imm, core_pkg::op_op};
	assign uses_rs2 = opcode inside {core_pkg::op_branch, core_pkg::op_store, core_pkg::op_op};

	assign hz_ex = id_ex.valid && id_ex.rf_wen && (id_ex.rd != 5'd0)
		&& ((uses_rs1 && id_ex.rd == rs1_addr) || (uses_rs2 && id_ex.rd == rs2_addr));
	assign hz_mem = ex_hazard.valid && ex_hazard.rf_wen && (ex_hazard.rd != 5'd0)
		&& ((uses_rs1 && ex_hazard.rd == rs1_addr) || (uses_rs2 && ex_hazard.rd == rs2_addr));

	// writeback needs no stall, the register file writes through
	assign stall = if_id.valid && (hz_ex || hz_mem);

	always_comb begin
		dec          = '0;
		dec.valid    = if_id.valid;
		dec.pc       = if_id.pc;
		dec.rd       = rd;
		dec.rs2_data = rs2_data;
		dec.alu_op   = core_pkg::alu_add;
		dec.br_kind  = core_pkg::br_none;
		dec.mem_cmd  = core_pkg::mem_none;
		dec.wb_sel   = core_pkg::wb_alu;
		dec.imm      = imm_i;
		dec.rf_wen   = 1'b0;
		case (opcode)
			core_pkg::op_lui: begin
				dec.alu_op = core_pkg::alu_copy_b;
				dec.imm    = imm_u;
				dec.rf_wen = 1'b1;
			end
			core_pkg::op_auipc: begin
				dec.imm    = imm_u;
				dec.rf_wen = 1'b1;
			end
			core_pkg::op_jal: begin
				dec.br_kind = core_pkg::br_jal;
				dec.imm     = imm_j;
				dec.wb_sel  = core_pkg::wb_pc4;
				dec.rf_wen  = 1'b1;
			end
			core_pkg::op_jalr: begin
				dec.br_kind = core_pkg::br_jalr;
				dec.wb_sel  = core_pkg::wb_pc4;
				dec.rf_wen  = 1'b1;
			end
			core_pkg::op_branch: begin
				dec.imm = imm_b;
				case (funct3)
					3'b000: dec.br_kind = core_pkg::br_beq;
					3'b001: dec.br_kind = core_pkg::br_bne;
					3'b100: dec.br_kind = core_pkg::br_blt;
					3'b101: dec.br_kind = core_pkg::br_bge;
					3'b110: dec.br_kind = core_pkg::br_bltu;
					3'b111: dec.br_kind = core_pkg::br_bgeu;
					default: dec.br_kind = core_pkg::br_none;
				endcase
			end
			core_pkg::op_load: begin
				dec.mem_cmd = core_pkg::mem_load;
				dec.wb_sel  = core_pkg::wb_mem;
				dec.rf_wen  = 1'b1;
			end
			core_pkg::op_store: begin
				dec.imm     = imm_s;
				dec.mem_cmd = core_pkg::mem_store;
			end
			core_pkg::op_op_imm: begin
				// bit 30 only selects sra among the immediates
				dec.alu_op = alu_of(funct3, (funct3 == 3'b101) && if_id.inst[30]);
				dec.rf_wen = 1'b1;
			end
			core_pkg::op_op: begin
				dec.alu_op = alu_of(funct3, if_id.inst[30]);
				dec.rf_wen = 1'b1;
			end
			default: ;
		endcase
		// operand selection
		dec.op1 = (opcode == core_pkg::op_auipc || opcode == core_pkg::op_jal)
			? if_id.pc : rs1_data;
		dec.op2 = (opcode == core_pkg::op_op || opcode == core_pkg::op_branch)
			? rs2_data : dec.imm;
	end

	// decode/execute register, bubble on stall or flush
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (stall || redirect.taken) begin
			id_ex <= '0;
		end else begin
			id_ex <= dec;
		end
	end

	a_flush_after_redirect: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect.taken |=> !id_ex.valid
	);

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire core_pkg::id_ex_t    id_ex,
	output core_pkg::redirect_t      redirect,
	output core_pkg::ex_mem_t        ex_mem
);

	logic [core_pkg::xlen-1:0] alu_out;
	logic [core_pkg::xlen-1:0] jalr_sum;
	logic [4:0]                shamt;
	logic                      br_cond;

	assign shamt = id_ex.op2[4:0];

	// ************************************************
	// ALU
	// ************************************************
	always_comb begin
		case (id_ex.alu_op)
			core_pkg::alu_add:    alu_out = id_ex.op1 + id_ex.op2;
			core_pkg::alu_sub:    alu_out = id_ex.op1 - id_ex.op2;
			core_pkg::alu_sll:    alu_out = id_ex.op1 << shamt;
			core_pkg::alu_slt:
				alu_out = {31'b0, $signed(id_ex.op1) < $signed(id_ex.op2)};
			core_pkg::alu_sltu:   alu_out = {31'b0, id_ex.op1 < id_ex.op2};
			core_pkg::alu_xor:    alu_out = id_ex.op1 ^ id_ex.op2;
			core_pkg::alu_srl:    alu_out = id_ex.op1 >> shamt;
			core_pkg::alu_sra:    alu_out = $unsigned($signed(id_ex.op1) >>> shamt);
			core_pkg::alu_or:     alu_out = id_ex.op1 | id_ex.op2;
			core_pkg::alu_and:    alu_out = id_ex.op1 & id_ex.op2;
			core_pkg::alu_copy_b: alu_out = id_ex.op2;
			default:              alu_out = '0;
		endcase
	end

	// ************************************************
	// branch condition and target
	// ************************************************
	always_comb begin
		case (id_ex.br_kind)
			core_pkg::br_beq:  br_cond = id_ex.op1 == id_ex.op2;
			core_pkg::br_bne:  br_cond = id_ex.op1 != id_ex.op2;
			core_pkg::br_blt:  br_cond = $signed(id_ex.op1) < $signed(id_ex.op2);
			core_pkg::br_bge:  br_cond = $signed(id_ex.op1) >= $signed(id_ex.op2);
			core_pkg::br_bltu: br_cond = id_ex.op1 < id_ex.op2;
			core_pkg::br_bgeu: br_cond = id_ex.op1 >= id_ex.op2;
			core_pkg::br_jal:  br_cond = 1'b1;
			core_pkg::br_jalr: br_cond = 1'b1;
			default:           br_cond = 1'b0;
		endcase
	end

	assign jalr_sum = id_ex.op1 + id_ex.imm;

	assign redirect.taken  = id_ex.valid && br_cond;
	// jalr clears bit 0, the rest are pc relative
	assign redirect.target = (id_ex.br_kind == core_pkg::br_jalr)
		? {jalr_sum[core_pkg::xlen-1:1], 1'b0} : id_ex.pc + id_ex.imm;

	// execute/memory register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem.valid    <= id_ex.valid;
			ex_mem.alu_out  <= alu_out;
			ex_mem.pc4      <= id_ex.pc + 32'd4;
			ex_mem.rs2_data <= id_ex.rs2_data;
			ex_mem.mem_cmd  <= id_ex.mem_cmd;
			ex_mem.rd       <= id_ex.rd;
			ex_mem.rf_wen   <= id_ex.rf_wen;
			ex_mem.wb_sel   <= id_ex.wb_sel;
		end
	end

	a_target_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		redirect.taken |-> redirect.target[1:0] == 2'b00
	);

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire core_pkg::ex_mem_t         ex_mem,
	output core_pkg::mem_cmd_e             d_cmd,
	output logic [core_pkg::xlen-1:0]      d_addr,
	output logic [core_pkg::xlen-1:0]      wdata,
	output logic [3:0]                     wmask,
	input  wire logic [core_pkg::xlen-1:0] rdata,
	output core_pkg::mem_wb_t              mem_wb
);

	logic [core_pkg::xlen-1:0] wb_data;

	// data port, bubbles issue no command
	assign d_cmd  = ex_mem.valid ? ex_mem.mem_cmd : core_pkg::mem_none;
	assign d_addr = ex_mem.alu_out;
	assign wdata  = ex_mem.rs2_data;
	// word stores only
	assign wmask  = (d_cmd == core_pkg::mem_store) ? 4'b1111 : 4'b0000;

	always_comb begin
		case (ex_mem.wb_sel)
			core_pkg::wb_mem: wb_data = rdata;
			core_pkg::wb_pc4: wb_data = ex_mem.pc4;
			default:          wb_data = ex_mem.alu_out;
		endcase
	end

	// memory/writeback register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.valid   <= ex_mem.valid;
			mem_wb.rd      <= ex_mem.rd;
			mem_wb.rf_wen  <= ex_mem.rf_wen;
			mem_wb.wb_data <= wb_data;
		end
	end

	a_cmd_needs_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		d_cmd != core_pkg::mem_none |-> ex_mem.valid
	);

endmodule

`default_nettype wire

/* core_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module core_pipeline (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	output logic [core_pkg::xlen-1:0]      i_addr,
	input  wire logic [core_pkg::xlen-1:0] inst,
	output core_pkg::mem_cmd_e             d_cmd,
	output logic [core_pkg::xlen-1:0]      d_addr,
	output logic [core_pkg::xlen-1:0]      wdata,
	output logic [3:0]                     wmask,
	input  wire logic [core_pkg::xlen-1:0] rdata,
	output logic                           retire_valid,
	output logic [4:0]                     retire_rd,
	output logic [core_pkg::xlen-1:0]      retire_data
);

	core_pkg::if_id_t          if_id;
	core_pkg::id_ex_t          id_ex;
	core_pkg::ex_mem_t         ex_mem;
	core_pkg::mem_wb_t         mem_wb;
	core_pkg::redirect_t       redirect;
	logic                      stall;
	logic [4:0]                rs1_addr;
	logic [4:0]                rs2_addr;
	logic [core_pkg::xlen-1:0] rs1_data;
	logic [core_pkg::xlen-1:0] rs2_data;

	// ************************************************
	// five stages plus register file
	// ************************************************
	fetch_stage u_fetch (
		.clk(clk), .rst_n(rst_n), .stall(stall), .redirect(redirect),
		.i_addr(i_addr), .inst(inst), .if_id(if_id)
	);

	decode_stage u_decode (
		.clk(clk), .rst_n(rst_n), .if_id(if_id),
		.ex_hazard(ex_mem), .wb_hazard(mem_wb), .redirect(redirect),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.stall(stall), .id_ex(id_ex)
	);

	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .redirect(redirect), .ex_mem(ex_mem)
	);

	memory_stage u_memory (
		.clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .d_cmd(d_cmd), .d_addr(d_addr),
		.wdata(wdata), .wmask(wmask), .rdata(rdata), .mem_wb(mem_wb)
	);

	register_file u_regfile (
		.clk(clk), .rst_n(rst_n), .mem_wb(mem_wb),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

endmodule

`default_nettype wire

/* tb_core_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core_pipeline;

	typedef struct packed {
		logic [4:0]                rd;
		logic [core_pkg::xlen-1:0] value;
	} retire_t;

	typedef struct packed {
		logic [core_pkg::xlen-1:0] addr;
		logic [core_pkg::xlen-1:0] data;
	} store_t;

	logic                      clk;
	logic                      rst_n;
	logic [core_pkg::xlen-1:0] i_addr;
	logic [core_pkg::xlen-1:0] inst;
	core_pkg::mem_cmd_e        d_cmd;
	logic [core_pkg::xlen-1:0] d_addr;
	logic [core_pkg::xlen-1:0] wdata;
	logic [3:0]                wmask;
	logic [core_pkg::xlen-1:0] rdata;
	logic                      retire_valid;
	logic [4:0]                retire_rd;
	logic [core_pkg::xlen-1:0] retire_data;

	logic [core_pkg::xlen-1:0] imem [0:255];
	logic [core_pkg::xlen-1:0] dmem [0:1023];
	retire_t                   retire_q [$];
	store_t                    store_q [$];
	int                        n_inst = 0;
	int                        cycles = 0;
	int                        cycle_limit = 0;

	core_pipeline u_dut (
		.clk(clk), .rst_n(rst_n), .i_addr(i_addr), .inst(inst),
		.d_cmd(d_cmd), .d_addr(d_addr), .wdata(wdata), .wmask(wmask), .rdata(rdata),
		.retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// ************************************************
	// memory models, both answer in the same cycle
	// ************************************************
	assign inst  = imem[i_addr[9:2]];
	assign rdata = dmem[d_addr[11:2]];

	always @(posedge clk) begin
		if (d_cmd == core_pkg::mem_store) begin
			dmem[d_addr[11:2]] <= wdata;
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
		end
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_retire(input logic [4:0] rd, input logic [core_pkg::xlen-1:0] value);
		retire_t exp;
		if (retire_q.size() == 0) begin
			abort_run($sformatf("[FAIL] %0d ns: unexpected retire x%0d = %h", $time, rd, value));
		end else begin
			exp = retire_q.pop_front();
			if (rd !== exp.rd || value !== exp.value) begin
				abort_run($sformatf("[FAIL] %0d ns: retire x%0d = %h, expected x%0d = %h",
					$time, rd, value, exp.rd, exp.value));
			end
		end
	endtask

	task automatic check_store(input core_pkg::mem_cmd_e cmd,
		input logic [core_pkg::xlen-1:0] addr, input logic [core_pkg::xlen-1:0] data,
		input logic [3:0] mask);
		store_t exp;
		if (store_q.size() == 0) begin
			abort_run($sformatf("[FAIL] %0d ns: unexpected store to %h", $time, addr));
		end else begin
			exp = store_q.pop_front();
			if (cmd !== core_pkg::mem_store || mask !== 4'b1111
				|| addr !== exp.addr || data !== exp.data) begin
				abort_run($sformatf("[FAIL] %0d ns: %s %h data %h mask %b, expected %h data %h",
					$time, cmd.name(), addr, data, mask, exp.addr, exp.data));
			end
		end
	endtask

	task automatic load_patterns();
		int                        fd;
		int                        n;
		logic [7:0]                tag;
		logic [8*160-1:0]          rest;
		logic [core_pkg::xlen-1:0] a;
		logic [core_pkg::xlen-1:0] b;
		retire_t                   r;
		store_t                    s;
		fd = $fopen("core_patterns.txt", "r");
		if (fd == 0) begin
			abort_run("could not open core_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", tag);
				if (n == 1) begin
					case (tag)
						"#": n = $fgets(rest, fd);
						"I": begin
							n = $fscanf(fd, "%h", a);
							imem[n_inst[7:0]] = a;
							n_inst++;
						end
						"D": begin
							n = $fscanf(fd, "%h %h", a, b);
							dmem[a[11:2]] = b;
						end
						"R": begin
							n = $fscanf(fd, "%d %h", a, b);
							r.rd = a[4:0];
							r.value = b;
							retire_q.push_back(r);
						end
						"S": begin
							n = $fscanf(fd, "%h %h", a, b);
							s.addr = a;
							s.data = b;
							store_q.push_back(s);
						end
						default: abort_run("core_patterns.txt holds a line with an unknown tag");
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n) begin
			if (retire_valid) begin
				check_retire(retire_rd, retire_data);
			end
			if (d_cmd == core_pkg::mem_store || wmask != 4'b0000) begin
				check_store(d_cmd, d_addr, wdata, wmask);
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		void'($urandom(32'hff41fbc5));
		// unused instruction slots hold addi x0 with the word index
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = {i[11:0], 20'h00013};
		end
		for (int i = 0; i < 1024; i++) begin
			dmem[i[9:0]] = $urandom();
		end
		load_patterns();
		cycle_limit = 10 * n_inst + 100;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		while ((retire_q.size() != 0 || store_q.size() != 0) && cycles < cycle_limit) begin
			@(posedge clk);
		end
		if (retire_q.size() == 0 && store_q.size() == 0) begin
			// closing jal x0 loop passes writeback twice with no retire
			repeat (6) @(posedge clk);
			$display("No errors");
			$finish;
		end else begin
			$display("timeout before all expected retires seen");
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* core_patterns.txt */
# I word | D address word | R rd(decimal) value | S address data
# hex unless noted, R and S lines are in program order
# arithmetic and dependencies
I 123450b7
I 00001197
I ff800213
I 40125293
I 01c25313
I 00122393
I 00433433
I 404304b3
I 0090c533
I 407255b3
I 7f036a13
I 004a7ab3
I 00431b13
I 00432bb3
# store, load back, load preset word, load-use add
I 00112223
I 00412603
I 00812683
I 00c68733
# branches, taken pair skips two markers, not-taken falls through
I 00630663
I 00100813
I 00100813
I fe430ce3
I 00431663
I 00100813
I 00100813
I fe631ce3
I 00624663
I 00100813
I 00100813
I fe434ce3
I 00435663
I 00100813
I 00100813
I fe625ce3
I 00436663
I 00100813
I 00100813
I fe626ce3
I 00627663
I 00100813
I 00100813
I fe437ce3
# jal, jalr with odd offset, add of links, self-loop on x0
I 00c008ef
I 00100813
I 00100813
I 01588967
I 00100813
I 00100813
I 012889b3
I 0000006f
D 000003f0 cafef00d
R 1 12345000
R 3 00001004
R 4 fffffff8
R 5 fffffffc
R 6 0000000f
R 7 00000001
R 8 00000001
R 9 00000017
R 10 12345017
R 11 fffffffc
R 20 000007ff
R 21 000007f8
R 22 000000f0
R 23 00000000
R 12 12345000
R 13 cafef00d
R 14 dd33400d
R 17 000000ac
R 18 000000b8
R 19 00000164
S 000003ec 12345000

/* verilog.f */
core_pkg.sv
register_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_pipeline.sv
tb_core_pipeline.sv

/* run_sim.sh */
#!/bin/sh
# build the core testbench with Verilator and run it from the project root
verilator --binary --timing --assert --top-module tb_core_pipeline -f verilog.f -Mdir obj_dir \
	&& ./obj_dir/Vtb_core_pipeline \
	|| { echo "simulation failed"; exit 1; }
